// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_csa_multiplier
FILELIST  = csa_multiplier.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIMFLAGS  = +verilator+error+limit+100000
SOURCES   = $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// File: csa_multiplier.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/partial_product_gen.sv
verilog/csa_row.sv
verilog/csa_array.sv
verilog/final_adder.sv
verilog/mul_pipe_ctrl.sv
verilog/csa_multiplier.sv
tb/csa_multiplier_asserts.sv
tb/tb_csa_multiplier.sv

// File: tb/csa_multiplier_asserts.sv
module csa_multiplier_asserts (
    input logic              clk,
    input logic              reset,
    input logic              in_valid,
    input logic              in_ready,
    input mul_pkg::mul_req_t in_req,
    input logic              out_valid,
    input logic              out_ready,
    input mul_pkg::product_t out_product
);

    import mul_pkg::*;

    int       fail_count = 0;
    product_t exp_q[$];     // True products of requests still in flight
    product_t exp_head;
    int       exp_count;
    logic     accepted_d;

    // ***********************************************************************
    // Reference model
    // ***********************************************************************

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            exp_head   <= '0;
            exp_count  <= 0;
            accepted_d <= 1'b0;
        end else begin
            // Oldest leaves before the newest joins
            if (out_valid && out_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(product_t'(in_req.a) * product_t'(in_req.b));
            end
            exp_count  <= exp_q.size();
            exp_head   <= (exp_q.size() != 0) ? exp_q[0] : '0;
            accepted_d <= in_valid & in_ready;
        end
    end

    // ***********************************************************************
    // Properties
    // ***********************************************************************

    a_reset_state: assert property (@(posedge clk)
        reset |=> !out_valid && in_ready)
        else begin
            fail_count++;
            $error("Pipeline not empty after reset");
        end

    a_match: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready |-> out_product == exp_head)
        else begin
            fail_count++;
            $error("Fail out_product 0x%08h expected 0x%08h",
                   $sampled(out_product), $sampled(exp_head));
        end

    a_orphan: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> exp_count != 0)
        else begin
            fail_count++;
            $error("Output valid with no request in flight");
        end

    // Held product must not move under a stall
    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_product))
        else begin
            fail_count++;
            $error("Output changed while the consumer stalled");
        end

    a_full: assert property (@(posedge clk) disable iff (reset)
        exp_count >= 2 && !out_ready |-> !in_ready)
        else begin
            fail_count++;
            $error("Input still ready with both stages full and stalled");
        end

    a_ready: assert property (@(posedge clk) disable iff (reset)
        out_ready |-> in_ready)
        else begin
            fail_count++;
            $error("Input stalled although the output side is free");
        end

    a_latency: assert property (@(posedge clk) disable iff (reset)
        accepted_d && (!out_valid || out_ready) |=> out_valid)
        else begin
            fail_count++;
            $error("Product did not appear two cycles after its accept");
        end

endmodule

bind csa_multiplier csa_multiplier_asserts asserts0 (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_req      (in_req),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product)
);

// File: tb/tb_csa_multiplier.sv
module tb_csa_multiplier;

    import mul_pkg::*;

    localparam int          TIMEOUT_CYCLES = 100;
    localparam logic [31:0] LFSR_SEED      = 32'h43f4;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    mul_req_t in_req;
    logic     out_valid;
    logic     out_ready = 1'b1;
    product_t out_product;

    logic [31:0] op_lfsr       = LFSR_SEED;
    logic [31:0] stall_lfsr    = LFSR_SEED;
    int          stall_mode    = 0;     // 0 free, 1 random stalls, 2 held off
    int          in_count      = 0;
    int          out_count     = 0;
    int          timeout_count = 0;
    int          errors;

    csa_multiplier dut0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_req      (in_req),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_product (out_product)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32 22 2 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ***********************************************************************
    // Consumer and transfer counters
    // ***********************************************************************

    always @(negedge clk) begin
        case (stall_mode)
            1: begin
                stall_lfsr = lfsr_next(stall_lfsr);
                stall_lfsr = lfsr_next(stall_lfsr);
                out_ready  = (stall_lfsr[1:0] != 2'b00);   // Stall one cycle in four
            end
            2: out_ready = 1'b0;
            default: out_ready = 1'b1;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            in_count  <= 0;
            out_count <= 0;
        end else begin
            if (in_valid && in_ready) in_count <= in_count + 1;
            if (out_valid && out_ready) out_count <= out_count + 1;
        end
    end

    // ***********************************************************************
    // Producer
    // ***********************************************************************

    task automatic send_request(input operand_t a, input operand_t b);
        int waited;
        @(negedge clk);
        in_valid = 1'b1;
        in_req   = '{a: a, b: b};
        waited   = 0;
        @(posedge clk);
        while (!in_ready && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!in_ready) begin
            timeout_count++;
            $display("Timeout: request %h x %h was never accepted", a, b);
        end
    endtask

    task automatic draw_operand(output operand_t value);
        value = '0;
        for (int i = 0; i < $bits(operand_t); i++) begin
            op_lfsr = lfsr_next(op_lfsr);
            value   = {value[$bits(operand_t)-2:0], op_lfsr[0]};
        end
    endtask

    // Idle gap after about one request in eight
    task automatic draw_gap(output logic gap);
        logic [2:0] gap_bits;
        gap_bits = '0;
        for (int i = 0; i < 3; i++) begin
            op_lfsr  = lfsr_next(op_lfsr);
            gap_bits = {gap_bits[1:0], op_lfsr[0]};
        end
        gap = (gap_bits == 3'b000);
    endtask

    task automatic send_random();
        operand_t a;
        operand_t b;
        draw_operand(a);
        draw_operand(b);
        send_request(a, b);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (out_count != in_count && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (out_count != in_count) begin
            timeout_count++;
            $display("Timeout: pipeline did not drain, %0d of %0d products seen",
                     out_count, in_count);
        end
    endtask

    // ***********************************************************************
    // Sequence
    // ***********************************************************************

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Corners back to back with the consumer always ready
        send_request(16'h0000, 16'h0000);
        send_request(16'h0000, 16'hffff);
        send_request(16'h0001, 16'hffff);
        send_request(16'hffff, 16'h0001);
        send_request(16'hffff, 16'hffff);
        send_request(16'hffff, 16'hff00);
        send_request(16'h1234, 16'hf00f);
        send_request(16'habcd, 16'h8000);
        send_request(16'h7fff, 16'he000);
        send_request(16'h8000, 16'h8000);
        idle_cycle();

        stall_mode = 1;
        for (int n = 0; n < 200; n++) begin
            logic gap;
            send_random();
            draw_gap(gap);
            if (gap) idle_cycle();
        end
        stall_mode = 0;
        idle_cycle();
        wait_drain();

        // Consumer held off and then released
        @(posedge clk);
        stall_mode = 2;
        fork
            repeat (4) send_random();
            begin
                repeat (8) @(posedge clk);
                stall_mode = 0;
            end
        join
        idle_cycle();
        wait_drain();

        errors = dut0.asserts0.fail_count + timeout_count;
        $display("Summary: %0d requests, %0d products, %0d assertion failures, %0d timeouts",
                 in_count, out_count, dut0.asserts0.fail_count, timeout_count);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/csa_array.sv
`include "mul_defines.svh"

module csa_array (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load,
    input  mul_pkg::product_t [`MUL_WIDTH-1:0] pp,
    output mul_pkg::cs_pair_t                  pair
);

    import mul_pkg::*;

    cs_pair_t pair_next;

    // ***********************************************************************
    // Row chain
    // ***********************************************************************

    // Row k folds pp[k] into the running pair
    genvar k;
    generate
        for (k = 1; k < `MUL_WIDTH; k++) begin : g_row
            cs_pair_t row_in;
            cs_pair_t row_out;

            if (k == 1) begin : g_first
                assign row_in = '{sum: pp[0], carry: '0};   // Seed with first row
            end else begin : g_next
                assign row_in = g_row[k-1].row_out;
            end

            csa_row row0 (
                .pair_in  (row_in),
                .pp       (pp[k]),
                .pair_out (row_out)
            );
        end
    endgenerate

    assign pair_next = g_row[`MUL_WIDTH-1].row_out;

    // ***********************************************************************
    // Stage 1 register
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            pair <= '0;
        end else if (load) begin
            pair <= pair_next;
        end
    end

endmodule

// File: verilog/csa_multiplier.sv
`include "mul_defines.svh"

module csa_multiplier (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  mul_pkg::mul_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output mul_pkg::product_t out_product
);

    mul_pkg::product_t [`MUL_WIDTH-1:0] pp;
    mul_pkg::cs_pair_t                  pair;
    logic                               stage1_load;
    logic                               stage2_load;

    partial_product_gen pp_gen0 (
        .req (in_req),
        .pp  (pp)
    );

    csa_array csa0 (
        .clk   (clk),
        .reset (reset),
        .load  (stage1_load),
        .pp    (pp),
        .pair  (pair)
    );

    final_adder cpa0 (
        .clk     (clk),
        .reset   (reset),
        .load    (stage2_load),
        .pair    (pair),
        .product (out_product)
    );

    mul_pipe_ctrl ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .out_ready   (out_ready),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .stage1_load (stage1_load),
        .stage2_load (stage2_load)
    );

endmodule

// File: verilog/csa_row.sv
`include "mul_defines.svh"

module csa_row (
    input  mul_pkg::cs_pair_t pair_in,
    input  mul_pkg::product_t pp,
    output mul_pkg::cs_pair_t pair_out
);

    import mul_pkg::*;

    product_t sum_bits;
    product_t carry_bits;   // Carry outs, one place up

    assign carry_bits[0] = 1'b0;

    // One full adder per bit position
    genvar i;
    generate
        for (i = 0; i < `PROD_WIDTH; i++) begin : g_fa
            logic s_in;
            logic c_in;
            logic p_in;

            assign s_in        = pair_in.sum[i];
            assign c_in        = pair_in.carry[i];
            assign p_in        = pp[i];
            assign sum_bits[i] = s_in ^ c_in ^ p_in;

            // Top carry out would fall beyond the product width
            if (i < `PROD_WIDTH - 1) begin : g_cout
                assign carry_bits[i+1] = (s_in & c_in) | (p_in & (s_in ^ c_in));
            end
        end
    endgenerate

    assign pair_out = '{sum: sum_bits, carry: carry_bits};

endmodule

// File: verilog/final_adder.sv
`include "mul_defines.svh"

module final_adder (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  mul_pkg::cs_pair_t pair,
    output mul_pkg::product_t product
);

    import mul_pkg::*;

    product_t result;

    // ***********************************************************************
    // Carry-propagate adder
    // ***********************************************************************

    // Ripple from bit 0 upward, last carry out is beyond the product
    always_comb begin : ripple
        logic c;

        c = 1'b0;
        for (int i = 0; i < `PROD_WIDTH; i++) begin
            result[i] = pair.sum[i] ^ pair.carry[i] ^ c;
            c         = (pair.sum[i] & pair.carry[i]) | (c & (pair.sum[i] ^ pair.carry[i]));
        end
    end

    // ***********************************************************************
    // Stage 2 register
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
        end else if (load) begin
            product <= result;    // Held while the consumer stalls
        end
    end

endmodule

// File: verilog/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// ***************************************************************************
// Multiplier widths
// ***************************************************************************

// Operand width of both multiplicand and multiplier
`define MUL_WIDTH 16

// Full unsigned product, twice the operand width
`define PROD_WIDTH (2 * `MUL_WIDTH)

`endif

// File: verilog/mul_pipe_ctrl.sv
module mul_pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic out_valid,
    output logic stage1_load,
    output logic stage2_load
);

    logic stage1_valid;
    logic stage2_valid;
    logic stage2_ready;

    // ***********************************************************************
    // Advance conditions
    // ***********************************************************************

    // Stage 2 frees up when empty or when its product is taken
    assign stage2_ready = ~stage2_valid | out_ready;

    assign stage2_load = stage1_valid & stage2_ready;    // Stage 1 moves down
    assign in_ready    = ~stage1_valid | stage2_ready;
    assign stage1_load = in_valid & in_ready;

    assign out_valid = stage2_valid;

    // ***********************************************************************
    // Stage valid bits
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1_valid <= 1'b0;
            stage2_valid <= 1'b0;
        end else begin
            // Refill, or keep a result that could not move on
            stage1_valid <= stage1_load | (stage1_valid & ~stage2_load);
            stage2_valid <= stage2_load | (stage2_valid & ~out_ready);
        end
    end

endmodule

// File: verilog/mul_pkg.sv
`include "mul_defines.svh"

package mul_pkg;

    typedef logic [`MUL_WIDTH-1:0]  operand_t;
    typedef logic [`PROD_WIDTH-1:0] product_t;   // Product, also a shifted partial product

    // One multiply request
    typedef struct packed {
        operand_t a;        // Multiplicand
        operand_t b;        // Multiplier
    } mul_req_t;

    // Redundant form, value is sum + carry
    typedef struct packed {
        product_t sum;
        product_t carry;    // Already weighted one place up
    } cs_pair_t;

endpackage

// File: verilog/partial_product_gen.sv
`include "mul_defines.svh"

module partial_product_gen (
    input  mul_pkg::mul_req_t                  req,
    output mul_pkg::product_t [`MUL_WIDTH-1:0] pp
);

    import mul_pkg::*;

    // ***********************************************************************
    // AND array
    // ***********************************************************************

    // One row per multiplier bit, placed at that bit's weight
    genvar i;
    generate
        for (i = 0; i < `MUL_WIDTH; i++) begin : g_pp
            operand_t row_bits;

            assign row_bits = req.a & {`MUL_WIDTH{req.b[i]}};
            assign pp[i]    = product_t'(row_bits) << i;   // Zero extend, then shift
        end
    endgenerate

endmodule
